// File: common/ex_pkg.sv
// Execute stage definitions shared by the ALU, the mul/div sequencer and its datapaths
package ex_pkg;

    // ----------------------------------------------------------------------
    // Datapath width
    // ----------------------------------------------------------------------

    // RV64 integer width
    localparam int xlen = 64;

    // ----------------------------------------------------------------------
    // Operation codes
    // ----------------------------------------------------------------------

    typedef enum logic [4:0] {
        // Single-cycle group
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_slt   = 5'd2,
        op_sltu  = 5'd3,
        op_and   = 5'd4,
        op_or    = 5'd5,
        op_xor   = 5'd6,
        op_sll   = 5'd7,
        op_srl   = 5'd8,
        op_sra   = 5'd9,
        // Multiply group, kept contiguous after the ALU ops
        op_mul   = 5'd10,
        op_mulh  = 5'd11,
        op_mulhu = 5'd12,
        // Divide group
        op_div   = 5'd13,
        op_divu  = 5'd14,
        op_rem   = 5'd15,
        op_remu  = 5'd16
    } alu_op_e;

    // Mul/div sequencer states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_done = 2'd2
    } muldiv_state_e;

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
// Execute ALU with single-cycle ops, word forms, mul/div hand-off and the result register
module ex_alu import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  logic            busy,
    input  alu_op_e         op,
    input  logic            word,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic            md_done,
    input  logic [xlen-1:0] mul_result,
    input  logic [xlen-1:0] div_result,
    output logic            md_start,
    output logic [xlen-1:0] result,
    output logic            result_valid,
    output logic [xlen-1:0] mem_addr
);

    // Sign-extend bit 31 into the upper word
    function automatic logic [xlen-1:0] sext_word(input logic [xlen-1:0] val);
        return {{(xlen/2){val[xlen/2-1]}}, val[xlen/2-1:0]};
    endfunction

    logic                   accept;
    logic                   is_md;
    logic                   sub;
    logic [xlen-1:0]        adder_b;
    logic [xlen:0]          adder_sum;
    logic                   slt_bit;
    logic                   sltu_bit;
    logic [5:0]             shamt;
    logic [xlen-1:0]        srl_in;
    logic signed [xlen-1:0] sra_in;
    logic [xlen-1:0]        alu_raw;
    logic                   word_op;
    logic [xlen-1:0]        alu_res;
    alu_op_e                md_op;
    logic                   md_word;
    logic [xlen-1:0]        md_sel;
    logic [xlen-1:0]        md_res;

    // ----------------------------------------------------------------------
    // Issue decode
    // ----------------------------------------------------------------------

    // Strobe only counts while the sequencer is idle
    assign accept   = issue & ~busy;
    // Mul and div codes sit above the ALU codes
    assign is_md    = (op >= op_mul);
    assign md_start = accept & is_md;

    // ----------------------------------------------------------------------
    // Single-cycle datapath
    // ----------------------------------------------------------------------

    // One adder for add, sub and both compares
    assign sub       = (op == op_sub) | (op == op_slt) | (op == op_sltu);
    assign adder_b   = sub ? ~src2 : src2;
    assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {{xlen{1'b0}}, sub};

    // Carry out set means no borrow
    assign sltu_bit = ~adder_sum[xlen];
    // On mixed signs the negative operand is the smaller one
    assign slt_bit  = (src1[xlen-1] ^ src2[xlen-1]) ? src1[xlen-1] : adder_sum[xlen-1];

    // Word shifts take five amount bits and the low word of src1
    assign shamt  = word ? {1'b0, src2[4:0]} : src2[5:0];
    assign srl_in = word ? {{(xlen/2){1'b0}}, src1[xlen/2-1:0]} : src1;
    assign sra_in = word ? sext_word(src1) : src1;

    always_comb begin
        case (op)
            op_add,
            op_sub:  alu_raw = adder_sum[xlen-1:0];
            op_slt:  alu_raw = {{(xlen-1){1'b0}}, slt_bit};
            op_sltu: alu_raw = {{(xlen-1){1'b0}}, sltu_bit};
            op_and:  alu_raw = src1 & src2;
            op_or:   alu_raw = src1 | src2;
            op_xor:  alu_raw = src1 ^ src2;
            op_sll:  alu_raw = src1 << shamt;
            op_srl:  alu_raw = srl_in >> shamt;
            op_sra:  alu_raw = sra_in >>> shamt;
            default: alu_raw = '0;
        endcase
    end

    // Word flag only matters for add, sub and shifts
    assign word_op = word & ((op == op_add) | (op == op_sub) | (op == op_sll) |
                             (op == op_srl) | (op == op_sra));
    assign alu_res = word_op ? sext_word(alu_raw) : alu_raw;

    // Load/store address, independent of op
    assign mem_addr = src1 + src2;

    // ----------------------------------------------------------------------
    // Mul/div result select
    // ----------------------------------------------------------------------

    assign md_sel = (md_op <= op_mulhu) ? mul_result : div_result;
    // Only plain mul has a word form here
    assign md_res = (md_word && (md_op == op_mul)) ? sext_word(md_sel) : md_sel;

    // Result register and one-cycle valid pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
            md_op        <= op_add;
            md_word      <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (accept && !is_md) begin
                result       <= alu_res;
                result_valid <= 1'b1;
            end else if (md_start) begin
                // Hold op and word flag for the select at completion
                md_op   <= op;
                md_word <= word;
            end else if (md_done) begin
                result       <= md_res;
                result_valid <= 1'b1;
            end
        end
    end

endmodule

// File: muldiv/muldiv_fsm.sv
`timescale 1ns/1ps
// Mul/div sequencer FSM driving load, step, busy and done
module muldiv_fsm import ex_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic last,
    output logic cnt_load,
    output logic step,
    output logic busy,
    output logic md_done
);

    muldiv_state_e state;
    muldiv_state_e state_nxt;

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (md_start) begin
                    state_nxt = st_run;
                end
            end
            // Leave after the 64th step
            st_run: begin
                if (last) begin
                    state_nxt = st_done;
                end
            end
            st_done: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    // Operands latch at the issuing edge
    assign cnt_load = (state == st_idle) & md_start;
    // One iteration per cycle in run
    assign step     = (state == st_run);
    assign busy     = (state != st_idle);
    // Datapath outputs settled, ALU registers them
    assign md_done  = (state == st_done);

endmodule

// File: muldiv/muldiv_step_counter.sv
`timescale 1ns/1ps
// Step counter for the mul/div sequencer, flags the last of 64 iterations
module muldiv_step_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic cnt_load,
    input  logic step,
    output logic last
);

    // 64 steps, counted 63 down to 0
    logic [5:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= 6'd63;
        end else if (step) begin
            // Wraps after the last step, reloaded before next use
            count <= count - 6'd1;
        end
    end

    // Final iteration in progress
    assign last = step & (count == 6'd0);

endmodule

// File: muldiv/seq_multiplier.sv
`timescale 1ns/1ps
// Shift-add multiplier, one multiplier bit per step, with sign fix-up and half select
module seq_multiplier import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cnt_load,
    input  logic            step,
    input  alu_op_e         op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] mul_result
);

    alu_op_e             op_q;
    logic                neg_q;
    logic                is_mulh;
    logic [xlen-1:0]     mag1;
    logic [xlen-1:0]     mag2;
    logic [xlen-1:0]     mcand;
    // High half accumulates, low half holds the remaining multiplier bits
    logic [2*xlen-1:0]   prod;
    logic [xlen:0]       part_sum;
    logic [2*xlen-1:0]   prod_fix;

    // ----------------------------------------------------------------------
    // Operand magnitudes
    // ----------------------------------------------------------------------

    // Signed handling for mulh only
    assign is_mulh = (op == op_mulh);
    assign mag1    = (is_mulh && src1[xlen-1]) ? -src1 : src1;
    assign mag2    = (is_mulh && src2[xlen-1]) ? -src2 : src2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q  <= op_mul;
            neg_q <= 1'b0;
        end else if (cnt_load) begin
            op_q  <= op;
            neg_q <= is_mulh & (src1[xlen-1] ^ src2[xlen-1]);
        end
    end

    // ----------------------------------------------------------------------
    // Iteration
    // ----------------------------------------------------------------------

    // Add multiplicand when the current multiplier bit is set, keep the carry
    assign part_sum = {1'b0, prod[2*xlen-1:xlen]} + {1'b0, mcand & {xlen{prod[0]}}};

    always_ff @(posedge clk) begin
        if (cnt_load) begin
            mcand <= mag1;
            prod  <= {{xlen{1'b0}}, mag2};
        end else if (step) begin
            // Shift right with carry into the top
            prod <= {part_sum, prod[xlen-1:1]};
        end
    end

    // Result
    assign prod_fix   = neg_q ? -prod : prod;
    // mul keeps the low half, mulh and mulhu the high half
    assign mul_result = (op_q == op_mul) ? prod_fix[xlen-1:0] : prod_fix[2*xlen-1:xlen];

endmodule

// File: muldiv/seq_divider.sv
`timescale 1ns/1ps
// Restoring divider, one quotient bit per step, with sign fix-up and RISC-V zero-divisor rule
module seq_divider import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cnt_load,
    input  logic            step,
    input  alu_op_e         op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] div_result
);

    alu_op_e         op_q;
    logic            q_neg;
    logic            r_neg;
    logic            is_signed;
    logic [xlen-1:0] mag1;
    logic [xlen-1:0] mag2;
    // Dividend bits shift out of quo as quotient bits shift in
    logic [xlen-1:0] quo;
    logic [xlen-1:0] rem;
    logic [xlen-1:0] dvs;
    logic [xlen:0]   rem_shift;
    logic [xlen:0]   trial;
    logic [xlen-1:0] quo_fix;
    logic [xlen-1:0] rem_fix;

    // ----------------------------------------------------------------------
    // Operand magnitudes and result signs
    // ----------------------------------------------------------------------

    assign is_signed = (op == op_div) | (op == op_rem);
    assign mag1      = (is_signed && src1[xlen-1]) ? -src1 : src1;
    assign mag2      = (is_signed && src2[xlen-1]) ? -src2 : src2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q  <= op_div;
            q_neg <= 1'b0;
            r_neg <= 1'b0;
        end else if (cnt_load) begin
            op_q  <= op;
            // Zero divisor keeps the all-ones quotient unsigned
            q_neg <= is_signed & (src1[xlen-1] ^ src2[xlen-1]) & (src2 != '0);
            // Remainder follows the dividend, which also restores it on zero divisor
            r_neg <= is_signed & src1[xlen-1];
        end
    end

    // ----------------------------------------------------------------------
    // Iteration
    // ----------------------------------------------------------------------

    // Bring down the next dividend bit and try the subtract
    assign rem_shift = {rem, quo[xlen-1]};
    assign trial     = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (cnt_load) begin
            quo <= mag1;
            rem <= '0;
            dvs <= mag2;
        end else if (step) begin
            if (!trial[xlen]) begin
                // Fits, keep the difference
                rem <= trial[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                // Restore
                rem <= rem_shift[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    // ----------------------------------------------------------------------
    // Result
    // ----------------------------------------------------------------------

    // Overflow case wraps back to the dividend with no extra logic
    assign quo_fix = q_neg ? -quo : quo;
    assign rem_fix = r_neg ? -rem : rem;

    assign div_result = ((op_q == op_div) || (op_q == op_divu)) ? quo_fix : rem_fix;

endmodule

// File: hdl/ex_unit.sv
`timescale 1ns/1ps
// Execute unit top joining the ALU, the mul/div sequencer and both iterative datapaths
module ex_unit import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  alu_op_e         op,
    input  logic            word,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result,
    output logic            result_valid,
    output logic            busy,
    output logic [xlen-1:0] mem_addr
);

    // Sequencer control
    logic            md_start;
    logic            md_done;
    logic            cnt_load;
    logic            step;
    logic            last;
    // Iterative datapath results
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_result;

    // ----------------------------------------------------------------------
    // ALU and result register
    // ----------------------------------------------------------------------

    ex_alu ex_alu_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .busy         (busy),
        .op           (op),
        .word         (word),
        .src1         (src1),
        .src2         (src2),
        .md_done      (md_done),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .md_start     (md_start),
        .result       (result),
        .result_valid (result_valid),
        .mem_addr     (mem_addr)
    );

    // ----------------------------------------------------------------------
    // Mul/div sequencing
    // ----------------------------------------------------------------------

    muldiv_fsm muldiv_fsm_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .md_start (md_start),
        .last     (last),
        .cnt_load (cnt_load),
        .step     (step),
        .busy     (busy),
        .md_done  (md_done)
    );

    muldiv_step_counter muldiv_step_counter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cnt_load (cnt_load),
        .step     (step),
        .last     (last)
    );

    // Both datapaths run every mul/div, ALU picks by latched op
    seq_multiplier seq_multiplier_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_load   (cnt_load),
        .step       (step),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .mul_result (mul_result)
    );

    seq_divider seq_divider_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_load   (cnt_load),
        .step       (step),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .div_result (div_result)
    );

endmodule

// File: test/ex_unit_props.sv
`timescale 1ns/1ps
// Protocol properties of the execute unit, attached to ex_unit by bind
module ex_unit_props import ex_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          issue,
    input logic          busy,
    input logic          md_start,
    input logic          result_valid,
    input muldiv_state_e fsm_state
);

    // ----------------------------------------------------------------------
    // Result and sequencer rules
    // ----------------------------------------------------------------------

    // Valid is a single-cycle pulse
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && $past(result_valid)))
        else $error("result_valid high on two consecutive cycles");

    // Busy only outside idle
    busy_state: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (fsm_state != st_idle))
        else $error("busy high while the mul/div FSM is idle");

    // No result while the sequencer runs
    busy_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !result_valid)
        else $error("result_valid high while busy");

    // Strobe during busy is dropped
    issue_dropped: assert property (@(posedge clk) disable iff (!rst_n)
        (issue && busy) |-> !md_start)
        else $error("md_start raised by an issue while busy");

endmodule

bind ex_unit ex_unit_props ex_unit_props_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .busy         (busy),
    .md_start     (md_start),
    .result_valid (result_valid),
    .fsm_state    (muldiv_fsm_inst.state)
);

// File: test/ex_unit_tb.sv
`timescale 1ns/1ps
// Testbench for the execute unit with directed vectors, a random ALU phase and a watchdog
module ex_unit_tb import ex_pkg::*; ();

    localparam int num_vec  = 40;
    localparam int num_rand = 40;
    localparam int alu_lat  = 1;
    localparam int md_lat   = 66;
    localparam int max_wait = 100;

    logic        clk;
    logic        rst_n;
    logic        issue;
    alu_op_e     op;
    logic        word;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] result;
    logic        result_valid;
    logic        busy;
    logic [63:0] mem_addr;

    // Directed vectors filled once at start
    alu_op_e     vec_op   [num_vec];
    logic        vec_word [num_vec];
    logic [63:0] vec_src1 [num_vec];
    logic [63:0] vec_src2 [num_vec];
    logic [63:0] vec_exp  [num_vec];
    int          vec_count;

    ex_unit ex_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .op           (op),
        .word         (word),
        .src1         (src1),
        .src2         (src2),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy),
        .mem_addr     (mem_addr)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Checking helpers
    // ----------------------------------------------------------------------

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_reset_values();
        check_value("result_valid", 64'(result_valid), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
        check_value("result", result, 64'd0);
    endtask

    // Ops that go through the mul/div sequencer
    function automatic logic multi_cycle(input alu_op_e vop);
        case (vop)
            op_mul, op_mulh, op_mulhu, op_div, op_divu, op_rem, op_remu: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected value for the random ops from the ISA definitions
    function automatic logic [63:0] ref_result(input alu_op_e vop, input logic vword,
                                               input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (vop)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_xor:  r = a ^ b;
            default: r = (a < b) ? 64'd1 : 64'd0;
        endcase
        if (vword) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Vector table
    // ----------------------------------------------------------------------

    task automatic add_vec(input alu_op_e vop, input logic vword, input logic [63:0] a,
                           input logic [63:0] b, input logic [63:0] expv);
        vec_op[vec_count]   = vop;
        vec_word[vec_count] = vword;
        vec_src1[vec_count] = a;
        vec_src2[vec_count] = b;
        vec_exp[vec_count]  = expv;
        vec_count++;
    endtask

    task automatic build_table();
        // Add and sub in plain and word form
        add_vec(op_add, 1'b0, 64'h7fff_ffff_ffff_ffff, 64'd1, 64'h8000_0000_0000_0000);
        add_vec(op_add, 1'b1, 64'h0000_0000_7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
        add_vec(op_sub, 1'b0, 64'd5, 64'd7, -64'd2);
        add_vec(op_sub, 1'b1, 64'h1234_5678_0000_0000, 64'd1, -64'd1);
        // Compares on mixed signs
        add_vec(op_slt,  1'b0, -64'd1, 64'd1, 64'd1);
        add_vec(op_sltu, 1'b0, -64'd1, 64'd1, 64'd0);
        add_vec(op_slt,  1'b0, 64'd1, -64'd1, 64'd0);
        add_vec(op_sltu, 1'b0, 64'd1, -64'd1, 64'd1);
        // Logic ops where the word flag has no effect
        add_vec(op_and, 1'b0, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0,
                64'h0f00_0f00_0f00_0f00);
        add_vec(op_and, 1'b1, -64'd1, 64'h0000_0000_8000_0000, 64'h0000_0000_8000_0000);
        add_vec(op_or, 1'b0, 64'hf000_0000_0000_000f, 64'h0f00_0000_0000_00f0,
                64'hff00_0000_0000_00ff);
        add_vec(op_xor, 1'b0, 64'haaaa_aaaa_aaaa_aaaa, 64'hffff_0000_ffff_0000,
                64'h5555_aaaa_5555_aaaa);
        // Shifts with amounts above 63 truncated to six bits
        add_vec(op_sll, 1'b0, 64'd1, 64'd63, 64'h8000_0000_0000_0000);
        add_vec(op_sll, 1'b0, 64'h0000_0000_0000_00ff, 64'h44, 64'h0000_0000_0000_0ff0);
        add_vec(op_sll, 1'b1, 64'd1, 64'h3f, 64'hffff_ffff_8000_0000);
        add_vec(op_srl, 1'b0, 64'hf000_0000_0000_0000, 64'h7c, 64'h0000_0000_0000_000f);
        add_vec(op_srl, 1'b1, 64'h0000_0000_8000_0000, 64'd0, 64'hffff_ffff_8000_0000);
        add_vec(op_sra, 1'b0, 64'h8000_0000_0000_0000, 64'h41, 64'hc000_0000_0000_0000);
        add_vec(op_sra, 1'b1, 64'h1234_5678_8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
        // Multiply
        add_vec(op_mul,   1'b0, 64'd3, 64'd5, 64'd15);
        add_vec(op_mul,   1'b0, -64'd3, -64'd5, 64'd15);
        add_vec(op_mul,   1'b1, 64'h1_0000, 64'h8000, 64'hffff_ffff_8000_0000);
        add_vec(op_mul,   1'b0, -64'd1, -64'd1, 64'd1);
        add_vec(op_mulh,  1'b0, -64'd3, -64'd5, 64'd0);
        add_vec(op_mulh,  1'b0, -64'd1, -64'd1, 64'd0);
        add_vec(op_mulh,  1'b0, 64'h8000_0000_0000_0000, 64'd2, -64'd1);
        add_vec(op_mulhu, 1'b0, 64'h8000_0000_0000_0000, 64'd2, 64'd1);
        add_vec(op_mulhu, 1'b0, -64'd1, -64'd1, -64'd2);
        // Divide with mixed signs
        add_vec(op_div,  1'b0, -64'd20, 64'd3, -64'd6);
        add_vec(op_rem,  1'b0, -64'd20, 64'd3, -64'd2);
        add_vec(op_div,  1'b0, 64'd20, -64'd3, -64'd6);
        add_vec(op_rem,  1'b0, 64'd20, -64'd3, 64'd2);
        add_vec(op_divu, 1'b0, -64'd20, 64'd3, 64'h5555_5555_5555_554e);
        add_vec(op_remu, 1'b0, -64'd20, 64'd3, 64'd2);
        // Zero divisor
        add_vec(op_div,  1'b0, 64'd20, 64'd0, -64'd1);
        add_vec(op_divu, 1'b0, 64'd20, 64'd0, -64'd1);
        add_vec(op_rem,  1'b0, -64'd20, 64'd0, -64'd20);
        add_vec(op_remu, 1'b0, 64'd20, 64'd0, 64'd20);
        // Most negative by minus one
        add_vec(op_div, 1'b0, 64'h8000_0000_0000_0000, -64'd1, 64'h8000_0000_0000_0000);
        add_vec(op_rem, 1'b0, 64'h8000_0000_0000_0000, -64'd1, 64'd0);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus tasks entered on a falling edge
    // ----------------------------------------------------------------------

    task automatic apply_vector(input alu_op_e vop, input logic vword, input logic [63:0] a,
                                input logic [63:0] b, input logic [63:0] expv);
        int   cycles;
        logic seen;
        logic md;
        md     = multi_cycle(vop);
        cycles = 0;
        seen   = 1'b0;
        op     = vop;
        word   = vword;
        src1   = a;
        src2   = b;
        issue  = 1'b1;
        // Address is combinational and settled by the rising edge
        @(posedge clk);
        check_value("mem_addr", mem_addr, a + b);
        while (!seen) begin
            @(negedge clk);
            issue = 1'b0;
            cycles++;
            if (result_valid) begin
                seen = 1'b1;
            end else begin
                if (md) begin
                    check_value("busy", 64'(busy), 64'd1);
                end
                assert (cycles < max_wait) else
                    fail_run("No result_valid within 100 cycles of issue");
            end
        end
        check_value("result", result, expv);
        check_value("latency", 64'(cycles), md ? 64'(md_lat) : 64'(alu_lat));
        check_value("busy", 64'(busy), 64'd0);
        // Idle cycle so the valid pulse ends before the next issue
        @(negedge clk);
        check_value("result_valid", 64'(result_valid), 64'd0);
    endtask

    // Second strobe in the middle of a divide must be dropped
    task automatic issue_while_busy();
        int valid_count;
        int valid_cycle;
        valid_count = 0;
        valid_cycle = 0;
        op    = op_div;
        word  = 1'b0;
        src1  = 64'd1000;
        src2  = 64'd7;
        issue = 1'b1;
        for (int c = 1; c <= md_lat + 20; c++) begin
            @(negedge clk);
            if (result_valid) begin
                valid_count++;
                valid_cycle = c;
                check_value("result", result, 64'd142);
            end
            // Multiply strobe while the divide runs
            if (c == 10) begin
                op    = op_mul;
                src1  = 64'd5;
                src2  = 64'd6;
                issue = 1'b1;
            end else begin
                issue = 1'b0;
            end
        end
        check_value("result_valid count", 64'(valid_count), 64'd1);
        check_value("latency", 64'(valid_cycle), 64'(md_lat));
    endtask

    task automatic random_phase();
        int unsigned sel;
        logic [31:0] rnd;
        alu_op_e     vop;
        logic        vword;
        logic [63:0] a;
        logic [63:0] b;
        for (int i = 0; i < num_rand; i++) begin
            sel = $urandom % 4;
            rnd = $urandom;
            a   = {$urandom, $urandom};
            b   = {$urandom, $urandom};
            case (sel)
                0: vop = op_add;
                1: vop = op_sub;
                2: vop = op_xor;
                default: vop = op_sltu;
            endcase
            // Word form only for add and sub
            vword = rnd[0] & ((vop == op_add) | (vop == op_sub));
            apply_vector(vop, vword, a, b, ref_result(vop, vword, a, b));
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        issue     = 1'b0;
        op        = op_add;
        word      = 1'b0;
        src1      = '0;
        src2      = '0;
        rst_n     = 1'b0;
        vec_count = 0;
        void'($urandom(32'h0e7f_067e));
        build_table();
        assert (vec_count == num_vec) else
            fail_run("Vector table holds a different number of entries than expected");
        // Reset held for 16 cycles
        repeat (16) begin
            @(negedge clk);
            check_reset_values();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_values();
        for (int i = 0; i < num_vec; i++) begin
            apply_vector(vec_op[i], vec_word[i], vec_src1[i], vec_src2[i], vec_exp[i]);
        end
        issue_while_busy();
        random_phase();
        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog allows 120 cycles of 40 ns per vector
    initial begin
        #((num_vec + num_rand) * 120 * 40);
        fail_run("Watchdog expired before the test sequence finished");
    end

endmodule

// File: files.f
common/ex_pkg.sv
hdl/ex_alu.sv
muldiv/muldiv_fsm.sv
muldiv/muldiv_step_counter.sv
muldiv/seq_multiplier.sv
muldiv/seq_divider.sv
hdl/ex_unit.sv
test/ex_unit_props.sv
test/ex_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module ex_unit_tb -o ex_unit_sim

./obj_dir/ex_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
